/* rtl/decode_pkg.sv */
package decode_pkg;

    // ------------------------------
    // Widths and counts
    // ------------------------------
    localparam int NUM_SLOTS   = 4;
    localparam int INSTR_W     = 32;
    localparam int XLEN        = 32;
    localparam int BUNDLE_W    = NUM_SLOTS * INSTR_W;
    localparam int QUEUE_DEPTH = 2;

    // Queue pointers wrap naturally, so depth stays a power of two
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Byte offset of a slot inside the 16-byte aligned bundle
    localparam int SLOT_OFFSET_SHIFT = 2;
    localparam int BUNDLE_OFFSET_W   = SLOT_OFFSET_SHIFT + $clog2(NUM_SLOTS);

    // ------------------------------
    // Types
    // ------------------------------
    typedef logic [INSTR_W-1:0]         instr_t;
    typedef logic [XLEN-1:0]            pc_t;
    typedef logic [BUNDLE_W-1:0]        bundle_t;
    typedef logic [NUM_SLOTS-1:0]       lane_mask_t;
    typedef logic [7:0]                 decode_flags_t;
    typedef logic [6:0]                 opcode_t;
    typedef logic [6:0]                 funct7_t;
    typedef logic [PTR_W-1:0]           qptr_t;
    typedef logic [CNT_W-1:0]           qcount_t;
    typedef logic [BUNDLE_OFFSET_W-1:0] byte_off_t;

    // Bit positions within decode_flags_t
    localparam int FLAG_RD_VALID = 0;
    localparam int FLAG_CSR      = 1;
    localparam int FLAG_DIV      = 2;
    localparam int FLAG_MUL      = 3;
    localparam int FLAG_BRANCH   = 4;
    localparam int FLAG_LSU      = 5;
    localparam int FLAG_EXEC     = 6;
    localparam int FLAG_INVALID  = 7;

    // ------------------------------
    // RV32IM major opcodes
    // ------------------------------
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;

    // funct7 values seen on register-register ops
    localparam funct7_t FUNCT7_BASE   = 7'b0000000;
    localparam funct7_t FUNCT7_ALT    = 7'b0100000;
    localparam funct7_t FUNCT7_MULDIV = 7'b0000001;

endpackage

/* rtl/fetch_fifo.sv */
`timescale 1ns/100ps

module fetch_fifo (
    input  logic                                          clk_i,
    input  logic                                          rst_i,

    input  logic                                          flush_i,

    // Fetch side
    input  logic                                          push_i,
    input  decode_pkg::bundle_t                           bundle_i,
    input  decode_pkg::pc_t                               pc_i,
    input  decode_pkg::lane_mask_t                        lane_mask_i,
    input  logic                                          fault_fetch_i,
    input  logic                                          fault_page_i,
    output logic                                          accept_o,

    // Issue side, one entry per slot
    input  decode_pkg::lane_mask_t                        pop_i,
    output decode_pkg::lane_mask_t                        valid_o,
    output decode_pkg::instr_t [decode_pkg::NUM_SLOTS-1:0] instr_o,
    output decode_pkg::pc_t    [decode_pkg::NUM_SLOTS-1:0] pc_o,
    output decode_pkg::lane_mask_t                        fault_fetch_o,
    output decode_pkg::lane_mask_t                        fault_page_o
);

    // ------------------------------
    // Storage
    // ------------------------------
    // Payload of each entry
    decode_pkg::bundle_t    bundle_q      [decode_pkg::QUEUE_DEPTH];
    decode_pkg::pc_t        pc_q          [decode_pkg::QUEUE_DEPTH];
    logic                   fault_fetch_q [decode_pkg::QUEUE_DEPTH];
    logic                   fault_page_q  [decode_pkg::QUEUE_DEPTH];

    // Slots still waiting to be taken, per entry
    decode_pkg::lane_mask_t slot_vld_q    [decode_pkg::QUEUE_DEPTH];

    decode_pkg::qptr_t      rd_ptr_q;
    decode_pkg::qptr_t      wr_ptr_q;
    decode_pkg::qcount_t    count_q;

    logic                   push_w;
    logic                   head_present_w;
    logic                   head_done_w;
    decode_pkg::lane_mask_t pop_w;
    logic                   entry_fault_w;

    // ------------------------------
    // Handshake
    // ------------------------------
    assign accept_o       = (count_q != decode_pkg::qcount_t'(decode_pkg::QUEUE_DEPTH));
    assign push_w         = push_i & accept_o;
    assign head_present_w = (count_q != '0);

    // Retired entries are left with an all-zero mask, so no count gating here
    assign valid_o        = slot_vld_q[rd_ptr_q];
    assign pop_w          = pop_i & valid_o;

    // Head retires once every slot is taken now or was never pending
    assign head_done_w    = head_present_w & (&(pop_w | ~valid_o));

    assign entry_fault_w  = fault_fetch_i | fault_page_i;

    // ------------------------------
    // Payload write
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (push_w && !flush_i) begin
            // Faulted fetch carries no usable instruction bits
            bundle_q[wr_ptr_q]      <= entry_fault_w ? '0 : bundle_i;
            pc_q[wr_ptr_q]          <= pc_i;
            fault_fetch_q[wr_ptr_q] <= fault_fetch_i;
            fault_page_q[wr_ptr_q]  <= fault_page_i;
        end
    end

    // ------------------------------
    // Pointers, count, slot valids
    // ------------------------------
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            for (int e = 0; e < decode_pkg::QUEUE_DEPTH; e++) begin
                slot_vld_q[e] <= '0;
            end
        end else if (flush_i) begin
            // Branch redirect drops everything, including a push on this edge
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            for (int e = 0; e < decode_pkg::QUEUE_DEPTH; e++) begin
                slot_vld_q[e] <= '0;
            end
        end else begin
            // Per-slot pops on the head entry
            if (head_present_w) begin
                slot_vld_q[rd_ptr_q] <= slot_vld_q[rd_ptr_q] & ~pop_w;
            end

            // Write pointer never equals a live head here
            if (push_w) begin
                slot_vld_q[wr_ptr_q] <= lane_mask_i;
                wr_ptr_q             <= wr_ptr_q + decode_pkg::qptr_t'(1);
            end

            if (head_done_w) begin
                rd_ptr_q <= rd_ptr_q + decode_pkg::qptr_t'(1);
            end

            if (push_w && !head_done_w) begin
                count_q <= count_q + decode_pkg::qcount_t'(1);
            end else if (!push_w && head_done_w) begin
                count_q <= count_q - decode_pkg::qcount_t'(1);
            end
        end
    end

    // ------------------------------
    // Head slot fan-out
    // ------------------------------
    always_comb begin
        for (int k = 0; k < decode_pkg::NUM_SLOTS; k++) begin
            instr_o[k] = bundle_q[rd_ptr_q][k*decode_pkg::INSTR_W +: decode_pkg::INSTR_W];

            // Slot PC is the aligned bundle PC plus the slot byte offset
            pc_o[k] = {pc_q[rd_ptr_q][decode_pkg::XLEN-1:decode_pkg::BUNDLE_OFFSET_W],
                       decode_pkg::byte_off_t'(k << decode_pkg::SLOT_OFFSET_SHIFT)};

            fault_fetch_o[k] = fault_fetch_q[rd_ptr_q];
            fault_page_o[k]  = fault_page_q[rd_ptr_q];
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_count_bound: assert property (
        @(posedge clk_i) disable iff (rst_i)
        count_q <= decode_pkg::qcount_t'(decode_pkg::QUEUE_DEPTH)
    );

    // Empty queue must leave no stale slot bits behind
    a_empty_quiet: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (count_q == '0) |-> (valid_o == '0)
    );

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder (
    input  logic                      valid_i,
    input  logic                      fault_i,
    input  decode_pkg::instr_t        instr_i,
    output decode_pkg::decode_flags_t flags_o
);

    // ------------------------------
    // Instruction fields
    // ------------------------------
    decode_pkg::opcode_t       opcode;
    logic [2:0]                funct3;
    decode_pkg::funct7_t       funct7;
    decode_pkg::decode_flags_t class_flags;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ------------------------------
    // Classification
    // ------------------------------
    always_comb begin
        class_flags = '0;

        case (opcode)
            decode_pkg::OPC_LOAD: begin
                class_flags[decode_pkg::FLAG_LSU]      = 1'b1;
                class_flags[decode_pkg::FLAG_RD_VALID] = 1'b1;
            end

            decode_pkg::OPC_STORE: begin
                class_flags[decode_pkg::FLAG_LSU] = 1'b1;
            end

            decode_pkg::OPC_OP_IMM,
            decode_pkg::OPC_LUI,
            decode_pkg::OPC_AUIPC: begin
                class_flags[decode_pkg::FLAG_EXEC]     = 1'b1;
                class_flags[decode_pkg::FLAG_RD_VALID] = 1'b1;
            end

            // Fences go down the ALU path as a no-op
            decode_pkg::OPC_MISC_MEM: begin
                class_flags[decode_pkg::FLAG_EXEC] = 1'b1;
            end

            decode_pkg::OPC_OP: begin
                if (funct7 == decode_pkg::FUNCT7_BASE || funct7 == decode_pkg::FUNCT7_ALT) begin
                    class_flags[decode_pkg::FLAG_EXEC]     = 1'b1;
                    class_flags[decode_pkg::FLAG_RD_VALID] = 1'b1;
                end else if (funct7 == decode_pkg::FUNCT7_MULDIV) begin
                    // funct3[2] splits MUL* from DIV/REM
                    if (funct3[2]) begin
                        class_flags[decode_pkg::FLAG_DIV] = 1'b1;
                    end else begin
                        class_flags[decode_pkg::FLAG_MUL] = 1'b1;
                    end
                    class_flags[decode_pkg::FLAG_RD_VALID] = 1'b1;
                end else begin
                    class_flags[decode_pkg::FLAG_INVALID] = 1'b1;
                end
            end

            decode_pkg::OPC_BRANCH: begin
                class_flags[decode_pkg::FLAG_BRANCH] = 1'b1;
            end

            // Jumps write the link register
            decode_pkg::OPC_JAL,
            decode_pkg::OPC_JALR: begin
                class_flags[decode_pkg::FLAG_BRANCH]   = 1'b1;
                class_flags[decode_pkg::FLAG_RD_VALID] = 1'b1;
            end

            decode_pkg::OPC_SYSTEM: begin
                class_flags[decode_pkg::FLAG_CSR] = 1'b1;
                // ECALL, EBREAK, MRET and friends have funct3 zero and no rd
                if (funct3 != 3'b000) begin
                    class_flags[decode_pkg::FLAG_RD_VALID] = 1'b1;
                end
            end

            default: begin
                class_flags[decode_pkg::FLAG_INVALID] = 1'b1;
            end
        endcase

        // One execution class per word, rd_valid aside
        a_one_class: assert ($onehot0(class_flags[decode_pkg::FLAG_INVALID:decode_pkg::FLAG_CSR]));
    end

    // Empty or faulted slots raise nothing
    assign flags_o = (valid_i && !fault_i) ? class_flags : '0;

endmodule

/* rtl/decode_top.sv */
`timescale 1ns/100ps

module decode_top (
    input  logic                                                 clk_i,
    input  logic                                                 rst_i,

    // Fetch bundle in
    input  logic                                                 fetch_valid_i,
    input  decode_pkg::bundle_t                                  fetch_bundle_i,
    input  decode_pkg::pc_t                                      fetch_pc_i,
    input  decode_pkg::lane_mask_t                               fetch_lane_mask_i,
    input  logic                                                 fetch_fault_fetch_i,
    input  logic                                                 fetch_fault_page_i,

    // Redirect
    input  logic                                                 branch_request_i,

    // Per-slot accept from issue
    input  decode_pkg::lane_mask_t                               slot_accept_i,

    output logic                                                 fetch_accept_o,

    // Per-slot outputs to issue
    output decode_pkg::lane_mask_t                               slot_valid_o,
    output decode_pkg::instr_t        [decode_pkg::NUM_SLOTS-1:0] slot_instr_o,
    output decode_pkg::pc_t           [decode_pkg::NUM_SLOTS-1:0] slot_pc_o,
    output decode_pkg::lane_mask_t                               slot_fault_fetch_o,
    output decode_pkg::lane_mask_t                               slot_fault_page_o,
    output decode_pkg::decode_flags_t [decode_pkg::NUM_SLOTS-1:0] slot_flags_o
);

    // ------------------------------
    // Bundle queue
    // ------------------------------
    fetch_fifo u_fifo (
        .clk_i         (clk_i),
        .rst_i         (rst_i),

        .flush_i       (branch_request_i),

        .push_i        (fetch_valid_i),
        .bundle_i      (fetch_bundle_i),
        .pc_i          (fetch_pc_i),
        .lane_mask_i   (fetch_lane_mask_i),
        .fault_fetch_i (fetch_fault_fetch_i),
        .fault_page_i  (fetch_fault_page_i),
        .accept_o      (fetch_accept_o),

        .pop_i         (slot_accept_i),
        .valid_o       (slot_valid_o),
        .instr_o       (slot_instr_o),
        .pc_o          (slot_pc_o),
        .fault_fetch_o (slot_fault_fetch_o),
        .fault_page_o  (slot_fault_page_o)
    );

    // ------------------------------
    // Decoders, one per slot
    // ------------------------------
    // Decode sits after the queue, so flags follow the head combinationally
    for (genvar k = 0; k < decode_pkg::NUM_SLOTS; k++) begin : g_slot
        instr_decoder u_dec (
            .valid_i (slot_valid_o[k]),
            .fault_i (slot_fault_fetch_o[k] | slot_fault_page_o[k]),
            .instr_i (slot_instr_o[k]),
            .flags_o (slot_flags_o[k])
        );
    end

    // ------------------------------
    // Checks
    // ------------------------------
    // A redirect leaves the queue empty and ready for the new path
    a_flush_ready: assert property (
        @(posedge clk_i) disable iff (rst_i)
        branch_request_i |=> (fetch_accept_o && slot_valid_o == '0)
    );

endmodule

/* dv/tb_decode_top.sv */
`timescale 1ns/100ps

module tb_decode_top;

    localparam int REC_WORDS   = 12;
    localparam int MAX_RECORDS = 64;
    localparam int WAIT_LIMIT  = 32;

    logic                                                 clk_i;
    logic                                                 rst_i;
    logic                                                 fetch_valid_i;
    decode_pkg::bundle_t                                  fetch_bundle_i;
    decode_pkg::pc_t                                      fetch_pc_i;
    decode_pkg::lane_mask_t                               fetch_lane_mask_i;
    logic                                                 fetch_fault_fetch_i;
    logic                                                 fetch_fault_page_i;
    logic                                                 branch_request_i;
    decode_pkg::lane_mask_t                               slot_accept_i;
    logic                                                 fetch_accept_o;
    decode_pkg::lane_mask_t                               slot_valid_o;
    decode_pkg::instr_t        [decode_pkg::NUM_SLOTS-1:0] slot_instr_o;
    decode_pkg::pc_t           [decode_pkg::NUM_SLOTS-1:0] slot_pc_o;
    decode_pkg::lane_mask_t                               slot_fault_fetch_o;
    decode_pkg::lane_mask_t                               slot_fault_page_o;
    decode_pkg::decode_flags_t [decode_pkg::NUM_SLOTS-1:0] slot_flags_o;

    // One record per file line: id, four slots, pc, mask, faults, four flags
    logic [31:0] stim_mem [MAX_RECORDS * REC_WORDS];
    int          num_records;
    int          num_tests;
    int          num_checks;
    int          num_errors;
    logic [31:0] rng_state;

    decode_top u_dut (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .fetch_valid_i       (fetch_valid_i),
        .fetch_bundle_i      (fetch_bundle_i),
        .fetch_pc_i          (fetch_pc_i),
        .fetch_lane_mask_i   (fetch_lane_mask_i),
        .fetch_fault_fetch_i (fetch_fault_fetch_i),
        .fetch_fault_page_i  (fetch_fault_page_i),
        .branch_request_i    (branch_request_i),
        .slot_accept_i       (slot_accept_i),
        .fetch_accept_o      (fetch_accept_o),
        .slot_valid_o        (slot_valid_o),
        .slot_instr_o        (slot_instr_o),
        .slot_pc_o           (slot_pc_o),
        .slot_fault_fetch_o  (slot_fault_fetch_o),
        .slot_fault_page_o   (slot_fault_page_o),
        .slot_flags_o        (slot_flags_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    // ------------------------------
    // Record fields and helpers
    // ------------------------------
    function automatic logic [31:0] fill_word(input int a);
        return {16'hffff, 16'(a)};
    endfunction

    function automatic logic [7:0] id_of(input int r);
        return stim_mem[r * REC_WORDS][7:0];
    endfunction

    function automatic decode_pkg::instr_t instr_of(input int r, input int k);
        return stim_mem[r * REC_WORDS + 1 + k];
    endfunction

    function automatic decode_pkg::pc_t pc_of(input int r);
        return stim_mem[r * REC_WORDS + 5];
    endfunction

    function automatic decode_pkg::lane_mask_t mask_of(input int r);
        return decode_pkg::lane_mask_t'(stim_mem[r * REC_WORDS + 6]);
    endfunction

    function automatic logic fault_fetch_of(input int r);
        return stim_mem[r * REC_WORDS + 7][1];
    endfunction

    function automatic logic fault_page_of(input int r);
        return stim_mem[r * REC_WORDS + 7][0];
    endfunction

    function automatic decode_pkg::decode_flags_t flags_of(input int r, input int k);
        return decode_pkg::decode_flags_t'(stim_mem[r * REC_WORDS + 8 + k]);
    endfunction

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_flags(input string what, input decode_pkg::decode_flags_t exp,
                               input decode_pkg::decode_flags_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("mismatch %s: expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic check_pc(input string what, input decode_pkg::pc_t exp,
                            input decode_pkg::pc_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("mismatch %s: expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic check_instr(input string what, input decode_pkg::instr_t exp,
                               input decode_pkg::instr_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("mismatch %s: expected %h actual %h", what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input decode_pkg::lane_mask_t exp,
                             input decode_pkg::lane_mask_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("mismatch %s: expected %b actual %b", what, exp, act);
        end
    endtask

    // ------------------------------
    // Fetch and issue side
    // ------------------------------
    task automatic drive_fetch(input int r);
        fetch_valid_i = 1'b1;
        for (int k = 0; k < decode_pkg::NUM_SLOTS; k++) begin
            fetch_bundle_i[k*decode_pkg::INSTR_W +: decode_pkg::INSTR_W] = instr_of(r, k);
        end
        fetch_pc_i          = pc_of(r);
        fetch_lane_mask_i   = mask_of(r);
        fetch_fault_fetch_i = fault_fetch_of(r);
        fetch_fault_page_i  = fault_page_of(r);
    endtask

    task automatic wait_fetch_taken(input string what);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            taken = fetch_accept_o;
            next_cycle();
            waited++;
        end
        fetch_valid_i = 1'b0;
        if (!taken) begin
            num_errors++;
            $display("fetch of %s was never accepted", what);
        end
    endtask

    task automatic push_record(input int r, input string what);
        drive_fetch(r);
        wait_fetch_taken(what);
    endtask

    task automatic wait_slots(input decode_pkg::lane_mask_t exp, input string what);
        int waited;
        waited = 0;
        while (slot_valid_o !== exp && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (slot_valid_o !== exp) begin
            num_errors++;
            $display("slots of %s did not show up in time", what);
        end
    endtask

    // Head must be record r with only the pending slots still valid
    task automatic check_head(input int r, input decode_pkg::lane_mask_t pending,
                              input string what);
        decode_pkg::pc_t    base_pc;
        decode_pkg::instr_t exp_instr;
        base_pc = pc_of(r);
        check_bit({what, " valid"}, pending, slot_valid_o);
        for (int k = 0; k < decode_pkg::NUM_SLOTS; k++) begin
            if (pending[k]) begin
                exp_instr = (fault_fetch_of(r) || fault_page_of(r)) ? '0 : instr_of(r, k);
                check_instr($sformatf("%s slot %0d instr", what, k), exp_instr, slot_instr_o[k]);
                check_pc($sformatf("%s slot %0d pc", what, k),
                         {base_pc[decode_pkg::XLEN-1:4], 4'(k * 4)}, slot_pc_o[k]);
                check_flags($sformatf("%s slot %0d flags", what, k), flags_of(r, k),
                            slot_flags_o[k]);
            end else begin
                check_flags($sformatf("%s slot %0d flags", what, k), '0, slot_flags_o[k]);
            end
        end
        if (pending != '0) begin
            check_bit({what, " fault fetch"}, {decode_pkg::NUM_SLOTS{fault_fetch_of(r)}},
                      slot_fault_fetch_o);
            check_bit({what, " fault page"}, {decode_pkg::NUM_SLOTS{fault_page_of(r)}},
                      slot_fault_page_o);
        end
    endtask

    // Random accepts, stray bits on idle slots included
    task automatic pop_random(input int r, input string what);
        decode_pkg::lane_mask_t pending;
        decode_pkg::lane_mask_t sel;
        int                     guard;
        pending = mask_of(r);
        guard   = 0;
        check_head(r, pending, what);
        while (pending != '0 && guard < WAIT_LIMIT) begin
            rng_state     = next_random(rng_state);
            sel           = rng_state[3:0];
            slot_accept_i = sel;
            next_cycle();
            slot_accept_i = '0;
            pending       = pending & ~sel;
            guard++;
            if (pending != '0) begin
                check_head(r, pending, what);
            end
        end
        if (pending != '0) begin
            num_errors++;
            $display("slots of %s were never all taken", what);
        end
    endtask

    task automatic end_test(input string name, input int start_errors);
        num_tests++;
        if (num_errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, num_errors - start_errors);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int    start;
        string name;
        rst_i               = 1'b1;
        fetch_valid_i       = 1'b0;
        fetch_bundle_i      = '0;
        fetch_pc_i          = '0;
        fetch_lane_mask_i   = '0;
        fetch_fault_fetch_i = 1'b0;
        fetch_fault_page_i  = 1'b0;
        branch_request_i    = 1'b0;
        slot_accept_i       = '0;
        rng_state           = 32'd52900;
        num_tests           = 0;
        num_checks          = 0;
        num_errors          = 0;
        for (int a = 0; a < MAX_RECORDS * REC_WORDS; a++) begin
            stim_mem[a] = fill_word(a);
        end
        $readmemh("dv/decode_stim.txt", stim_mem);
        num_records = 0;
        while (num_records < MAX_RECORDS &&
               stim_mem[num_records * REC_WORDS] != fill_word(num_records * REC_WORDS)) begin
            num_records++;
        end
        repeat (4) @(posedge clk_i);
        #2;
        rst_i = 1'b0;

        start = num_errors;
        if (num_records < 6) begin
            num_errors++;
            $display("stimulus file holds only %0d records", num_records);
        end
        check_bit("reset valid", '0, slot_valid_o);
        check_bit("reset accept", 4'b0001, {3'b000, fetch_accept_o});
        for (int k = 0; k < decode_pkg::NUM_SLOTS; k++) begin
            check_flags($sformatf("reset slot %0d flags", k), '0, slot_flags_o[k]);
        end
        end_test("reset", start);

        // Every record alone, slots taken in random order
        for (int r = 0; r < num_records; r++) begin
            start = num_errors;
            name  = $sformatf("record %02h", id_of(r));
            push_record(r, name);
            wait_slots(mask_of(r), name);
            pop_random(r, name);
            rng_state = next_random(rng_state);
            repeat (rng_state[5:4]) next_cycle();
            end_test(name, start);
        end
        next_cycle();

        // Third bundle waits behind a full queue
        start = num_errors;
        push_record(0, "backpressure first");
        push_record(1, "backpressure second");
        drive_fetch(2);
        repeat (3) begin
            check_bit("backpressure accept", '0, {3'b000, fetch_accept_o});
            check_head(0, mask_of(0), "backpressure hold");
            next_cycle();
        end
        pop_random(0, "backpressure head 0");
        wait_fetch_taken("backpressure third");
        wait_slots(mask_of(1), "backpressure head 1");
        pop_random(1, "backpressure head 1");
        wait_slots(mask_of(2), "backpressure head 2");
        pop_random(2, "backpressure head 2");
        end_test("backpressure", start);

        // Redirect with two bundles queued
        start = num_errors;
        push_record(3, "flush first");
        push_record(4, "flush second");
        wait_slots(mask_of(3), "flush first");
        check_bit("flush full accept", '0, {3'b000, fetch_accept_o});
        branch_request_i = 1'b1;
        next_cycle();
        branch_request_i = 1'b0;
        check_bit("flush valid", '0, slot_valid_o);
        check_bit("flush accept", 4'b0001, {3'b000, fetch_accept_o});
        push_record(5, "flush new head");
        wait_slots(mask_of(5), "flush new head");
        pop_random(5, "flush new head");
        end_test("flush", start);

        $display("tests=%0d checks=%0d errors=%0d", num_tests, num_checks, num_errors);
        if (num_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Budget of 40 cycles per record plus setup
    initial begin
        #1;
        repeat (num_records * 40 + 200) @(posedge clk_i);
        $display("watchdog expired after %0d cycles", num_records * 40 + 200);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

/* dv/decode_stim.txt */
// id slot0 slot1 slot2 slot3 pc lane_mask fault(bit1 fetch, bit0 page)
// then expected decode flags for slot0 slot1 slot2 slot3, unmasked or faulted slots are 00
01 00012083 00112023 00100093 000010b7 00001000 f 0 21 20 41 41
02 00001097 0ff0000f 003100b3 403100b3 00001010 f 0 41 40 41 41
03 023100b3 023140b3 023170b3 023130b3 00001020 f 0 09 05 05 09
04 00208463 008000ef 000080e7 300110f3 00001030 f 0 10 11 11 03
05 00000073 00100073 043100b3 00000000 00001040 f 0 02 02 80 80
06 ffffffff 00012083 00112023 00100093 8000000c f 0 80 21 20 41
07 00012083 00112023 00100093 000010b7 00002004 3 0 21 20 00 00
08 003100b3 403100b3 023100b3 023140b3 00002018 c 0 00 00 09 05
09 00208463 008000ef 000080e7 300110f3 00002020 5 0 10 00 11 00
0a 00000073 00100093 0ff0000f 00012083 0000202c a 0 00 41 00 21
0b 00112023 00012083 003100b3 008000ef 00002030 8 0 00 00 00 11
0c 000080e7 00112023 023130b3 043100b3 00002040 1 0 11 00 00 00
0d 000010b7 00001097 023140b3 00000073 00002050 0 0 00 00 00 00
0e 00012083 00112023 00100093 000010b7 00003000 f 2 00 00 00 00
0f 023100b3 023140b3 00208463 008000ef 00003010 f 1 00 00 00 00
10 003100b3 300110f3 00012083 00112023 00003024 6 3 00 00 00 00
11 403100b3 023170b3 00100073 00001097 40000ff0 f 0 41 05 02 41
12 0ff0000f 023130b3 000080e7 000010b7 40001000 e 0 00 09 11 41
13 ffffffff 00000000 043100b3 003100b3 40001014 7 0 80 80 80 00
14 300110f3 00000073 023100b3 00112023 7ffffff8 f 0 03 02 09 20
15 00100093 008000ef 00208463 023140b3 fffffff0 9 0 41 00 00 05
16 00012083 00012083 00112023 00112023 00004000 b 0 21 21 00 20
17 008000ef 008000ef 003100b3 0ff0000f 00004010 4 2 00 00 00 00
18 000010b7 023170b3 300110f3 00100073 00004020 f 0 41 05 03 02

/* all.f */
rtl/decode_pkg.sv
rtl/fetch_fifo.sv
rtl/instr_decoder.sv
rtl/decode_top.sv
dv/tb_decode_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_decode_top -Mdir obj_dir -f all.f \
    && ./obj_dir/Vtb_decode_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1
exit 0
